//--- hw/hps_bus_pkg.sv
// host bus definitions
package hps_bus_pkg;

	// port and register counts
	parameter int NUM_PS2_PORTS = 2;
	parameter int NUM_JOY       = 2;
	parameter int STATUS_WORDS  = 8;

	// kept host commands
	typedef enum logic [7:0] {
		op_cfg      = 8'h01,
		op_joy0     = 8'h02,
		op_joy1     = 8'h03,
		op_mouse    = 8'h04,
		op_kbd      = 8'h05,
		op_status   = 8'h1e,
		op_ps2_read = 8'h21,
		op_rumble   = 8'h3f
	} opcode_e;

	// first word of a command
	// rumble carries the joystick index in the upper byte
	typedef union packed {
		logic [15:0] opcode;
		struct packed {
			logic [7:0] index;
			logic [7:0] opcode;
		} indexed;
	} cmd_word_u;

	// one word as seen on the bus
	typedef struct packed {
		logic        strobe;
		logic [15:0] data;
	} host_word_s;

	// ps2 data word, marker of all ones means skip
	typedef union packed {
		logic [15:0] word;
		struct packed {
			logic [7:0] marker;
			logic [7:0] data;
		} fields;
	} ps2_byte_u;

endpackage

//--- hw/ps2_pkg.sv
// ps2 link definitions
package ps2_pkg;

	// byte from the decoder into a port fifo
	typedef struct packed {
		logic       valid;
		logic [7:0] data;
	} ps2_wr_s;

	// byte received by a port, waiting for the host
	typedef struct packed {
		logic       has_data;
		logic [7:0] data;
	} ps2_rd_s;

	// compact keyboard event
	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic       extended;
		logic [7:0] code;
	} key_event_s;

	// one direction of a ps2 line pair
	typedef struct packed {
		logic clk;
		logic dat;
	} ps2_lines_s;

endpackage

//--- hw/hps_cmd_decoder.sv
// host command decoder
`timescale 1ns/1ns

module hps_cmd_decoder #(
	parameter int FIFO_DEPTH = 8,
	parameter int PS2_DIV    = 4
) (
	input  logic                                           clk_sys,
	input  logic                                           rst,
	input  logic                                           enable,
	input  logic                                           strobe,
	input  logic [15:0]                                    din,
	input  logic [hps_bus_pkg::NUM_JOY-1:0][15:0]          rumble,
	input  logic [hps_bus_pkg::NUM_PS2_PORTS-1:0]          credit_return,
	input  ps2_pkg::ps2_rd_s                               reply,
	output logic [15:0]                                    dout,
	output logic [1:0]                                     buttons,
	output logic [hps_bus_pkg::NUM_JOY-1:0][31:0]          joystick,
	output logic [hps_bus_pkg::STATUS_WORDS*16-1:0]        status,
	output ps2_pkg::key_event_s                            ps2_key,
	output ps2_pkg::ps2_wr_s [hps_bus_pkg::NUM_PS2_PORTS-1:0] wr,
	output logic                                           sel_valid,
	output logic [$clog2(hps_bus_pkg::NUM_PS2_PORTS)-1:0]  sel_port
);

	localparam int cw = $clog2(FIFO_DEPTH + 1);
	localparam int pw = $clog2(hps_bus_pkg::NUM_PS2_PORTS);
	localparam int jw = $clog2(hps_bus_pkg::NUM_JOY);
	localparam bit ps2_on = (PS2_DIV != 0);
	localparam int kbd_port = 0;
	localparam int mouse_port = 1;

	hps_bus_pkg::host_word_s host;
	hps_bus_pkg::cmd_word_u  cmd_in;
	hps_bus_pkg::cmd_word_u  cmd;
	hps_bus_pkg::ps2_byte_u  ps2_in;

	logic [7:0]  word_cnt;
	logic        data_word;
	logic        ps2skip;
	logic        skip_word;
	logic        skip_now;
	logic        joy_idx;
	logic [31:0] key_raw;
	logic [15:0] rumble_q;
	logic        rumble_pend;
	logic        reply_pend;

	logic [hps_bus_pkg::NUM_PS2_PORTS-1:0]         port_req;
	logic [hps_bus_pkg::NUM_PS2_PORTS-1:0][cw-1:0] credit;

	ps2_pkg::key_event_s key_next;

	assign host.strobe = strobe;
	assign host.data   = din;
	assign cmd_in      = host.data;
	assign ps2_in      = host.data;

	assign data_word = enable && host.strobe && (word_cnt != 8'd0);
	assign skip_word = &ps2_in.fields.marker;
	assign skip_now  = ps2skip || skip_word;
	assign joy_idx   = (cmd.opcode == 16'(hps_bus_pkg::op_joy1));

	//////////////////////////////////////////////////////////////////////
	// ps2 writes under credit control
	//////////////////////////////////////////////////////////////////////

	assign port_req[kbd_port] = data_word && !skip_now &&
		(cmd.opcode == 16'(hps_bus_pkg::op_kbd));
	assign port_req[mouse_port] = data_word && !skip_now &&
		(cmd.opcode == 16'(hps_bus_pkg::op_mouse));

	always_comb begin
		for (int i = 0; i < hps_bus_pkg::NUM_PS2_PORTS; i++) begin
			// no credit, byte is dropped
			wr[i].valid = ps2_on && port_req[i] && (credit[i] != '0);
			wr[i].data  = ps2_in.fields.data;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			for (int i = 0; i < hps_bus_pkg::NUM_PS2_PORTS; i++) begin
				credit[i] <= cw'(FIFO_DEPTH);
			end
		end else begin
			for (int i = 0; i < hps_bus_pkg::NUM_PS2_PORTS; i++) begin
				credit[i] <= credit[i] - cw'(wr[i].valid) + cw'(credit_return[i]);
			end
		end
	end

	// readback select, word n reads port n-1
	assign sel_valid = ps2_on && data_word &&
		(cmd.opcode == 16'(hps_bus_pkg::op_ps2_read)) &&
		(word_cnt <= 8'(hps_bus_pkg::NUM_PS2_PORTS));
	assign sel_port = pw'(word_cnt - 8'd1);

	//////////////////////////////////////////////////////////////////////
	// keyboard event
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		key_next.toggle   = ~ps2_key.toggle;
		key_next.pressed  = (key_raw[15:8] != 8'hf0);
		key_next.extended = key_next.pressed ? (key_raw[15:8] == 8'he0) :
			(key_raw[23:16] == 8'he0);
		key_next.code     = key_raw[7:0];
		case (key_raw)
			// print screen make
			32'he012e07c: begin
				key_next.pressed  = 1'b1;
				key_next.extended = 1'b1;
				key_next.code     = 8'h7c;
			end
			// print screen break
			32'h7ce0f012: begin
				key_next.pressed  = 1'b0;
				key_next.extended = 1'b1;
				key_next.code     = 8'h7c;
			end
			// pause, make only
			32'hf014f077: begin
				key_next.pressed  = 1'b1;
				key_next.extended = 1'b1;
				key_next.code     = 8'h77;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (enable && host.strobe) begin
			if (word_cnt == 8'd0) begin
				if (cmd_in.opcode == 16'(hps_bus_pkg::op_kbd)) key_raw <= '0;
			end else if (port_req[kbd_port]) begin
				key_raw <= {key_raw[23:0], ps2_in.fields.data};
			end
		end
	end

	// rumble selection stage
	always_ff @(posedge clk_sys) begin
		if (enable && host.strobe && (word_cnt == 8'd0)) begin
			if (cmd_in.indexed.index < 8'(hps_bus_pkg::NUM_JOY))
				rumble_q <= rumble[cmd_in.indexed.index[jw-1:0]];
			else
				rumble_q <= '0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// command sequencing and registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			word_cnt    <= '0;
			cmd         <= '0;
			ps2skip     <= 1'b0;
			dout        <= '0;
			reply_pend  <= 1'b0;
			rumble_pend <= 1'b0;
			buttons     <= '0;
			joystick    <= '0;
			status      <= '0;
			ps2_key     <= '0;
		end else begin
			reply_pend  <= sel_valid;
			rumble_pend <= 1'b0;
			if (reply_pend) dout <= {7'd0, reply};
			if (rumble_pend) dout <= rumble_q;

			if (!enable) begin
				// end of command
				if ((cmd.opcode == 16'(hps_bus_pkg::op_kbd)) && !ps2skip)
					ps2_key <= key_next;
				word_cnt <= '0;
				cmd      <= '0;
				ps2skip  <= 1'b0;
			end else if (host.strobe) begin
				dout <= '0;
				if (word_cnt != 8'hff) word_cnt <= word_cnt + 8'd1;

				if (word_cnt == 8'd0) begin
					cmd <= cmd_in;
					if (cmd_in.indexed.opcode == hps_bus_pkg::op_rumble)
						rumble_pend <= 1'b1;
				end else begin
					case (cmd.opcode)
						16'(hps_bus_pkg::op_cfg): buttons <= host.data[1:0];
						16'(hps_bus_pkg::op_joy0),
						16'(hps_bus_pkg::op_joy1): begin
							if (word_cnt == 8'd1) joystick[joy_idx][15:0] <= host.data;
							if (word_cnt == 8'd2) joystick[joy_idx][31:16] <= host.data;
						end
						16'(hps_bus_pkg::op_status): begin
							if (word_cnt <= 8'(hps_bus_pkg::STATUS_WORDS))
								status[16*(word_cnt-8'd1) +: 16] <= host.data;
						end
						16'(hps_bus_pkg::op_kbd),
						16'(hps_bus_pkg::op_mouse): begin
							if (skip_word) ps2skip <= 1'b1;
						end
						default: ;
					endcase
				end
			end
		end
	end

endmodule

//--- hw/ps2_port.sv
// emulated ps2 device
`timescale 1ns/1ns

module ps2_port #(
	parameter int FIFO_DEPTH = 8,
	parameter int PS2_DIV    = 4
) (
	input  logic                clk_sys,
	input  logic                rst,
	input  ps2_pkg::ps2_wr_s    wr,
	input  ps2_pkg::ps2_lines_s lines_in,
	input  logic                rd_ack,
	output ps2_pkg::ps2_lines_s lines_out,
	output logic                credit_return,
	output ps2_pkg::ps2_rd_s    rd
);

	localparam int div = (PS2_DIV < 1) ? 1 : PS2_DIV;
	localparam int dw  = (div > 1) ? $clog2(div) : 1;
	localparam int aw  = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int cw  = $clog2(FIFO_DEPTH + 1);

	typedef enum logic [2:0] {
		rx_idle,
		rx_wait,
		rx_bits,
		rx_stop,
		rx_ack
	} rx_state_e;

	logic [dw-1:0] div_cnt;
	logic          ps2_clk;
	logic          tick;
	logic          ps2_rise;
	logic          ps2_fall;

	logic [7:0]    fifo [FIFO_DEPTH];
	logic [aw-1:0] wptr;
	logic [aw-1:0] rptr;
	logic [cw-1:0] count;

	logic          c1;
	logic          d1;
	logic          d2;
	logic [3:0]    tx_cnt;
	logic [7:0]    tx_shift;
	logic          tx_parity;
	logic [1:0]    gap;
	logic          tx_start;
	logic          rts;

	rx_state_e     rx_state;
	logic [3:0]    rx_cnt;
	logic [7:0]    rx_shift;
	logic          has_data;
	logic [7:0]    rd_data;

	assign rd = '{has_data: has_data, data: rd_data};

	//////////////////////////////////////////////////////////////////////
	// ps2 clock, period of 2*PS2_DIV system clocks
	//////////////////////////////////////////////////////////////////////

	assign tick     = (div_cnt == dw'(div - 1));
	assign ps2_rise = tick && !ps2_clk;
	assign ps2_fall = tick && ps2_clk;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			div_cnt <= '0;
			ps2_clk <= 1'b0;
		end else if (tick) begin
			div_cnt <= '0;
			ps2_clk <= ~ps2_clk;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// line sync, idle high
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			c1 <= 1'b1;
			d1 <= 1'b1;
			d2 <= 1'b1;
		end else begin
			c1 <= lines_in.clk;
			d1 <= lines_in.dat;
			d2 <= d1;
		end
	end

	// start a frame only on idle high lines
	assign tx_start = ps2_rise && (tx_cnt == 4'd0) && (rx_state == rx_idle) &&
		(gap == 2'd0) && (count != '0) && c1 && d1;
	// request to send, data falls while clock high
	assign rts = (tx_cnt == 4'd0) && (rx_state == rx_idle) && c1 && d2 && !d1;

	//////////////////////////////////////////////////////////////////////
	// transmit fifo
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (wr.valid) fifo[wptr] <= wr.data;
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			wptr          <= '0;
			rptr          <= '0;
			count         <= '0;
			credit_return <= 1'b0;
		end else begin
			if (wr.valid) wptr <= (wptr == aw'(FIFO_DEPTH - 1)) ? '0 : wptr + 1'b1;
			if (tx_start) rptr <= (rptr == aw'(FIFO_DEPTH - 1)) ? '0 : rptr + 1'b1;
			count         <= count + cw'(wr.valid) - cw'(tx_start);
			credit_return <= tx_start;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// frame control
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			tx_cnt    <= '0;
			gap       <= '0;
			rx_state  <= rx_idle;
			rx_cnt    <= '0;
			has_data  <= 1'b0;
			lines_out <= '{clk: 1'b1, dat: 1'b1};
		end else begin
			if (rd_ack) has_data <= 1'b0;
			if (rts) begin
				rx_state      <= rx_wait;
				lines_out.dat <= 1'b1;
			end

			if (ps2_rise) begin
				lines_out.clk <= 1'b1;
				if (rx_state != rx_idle) begin
					case (rx_state)
						rx_wait: begin
							rx_state <= rx_bits;
							rx_cnt   <= '0;
						end
						rx_bits: begin
							// ninth edge carries parity, not checked
							if (rx_cnt < 4'd8) rx_cnt <= rx_cnt + 4'd1;
							else rx_state <= rx_stop;
						end
						rx_stop: begin
							if (d1) begin
								lines_out.dat <= 1'b0;
								rx_state      <= rx_ack;
							end
						end
						default: begin
							lines_out.dat <= 1'b1;
							has_data      <= 1'b1;
							rx_state      <= rx_idle;
						end
					endcase
				end else if (tx_cnt == 4'd0) begin
					if (gap != 2'd0) begin
						gap <= gap - 2'd1;
					end else if (tx_start) begin
						// start bit
						lines_out.dat <= 1'b0;
						tx_cnt        <= 4'd1;
					end
				end else begin
					if (tx_cnt <= 4'd8) lines_out.dat <= tx_shift[0];
					else if (tx_cnt == 4'd9) lines_out.dat <= tx_parity;
					else lines_out.dat <= 1'b1;
					if (tx_cnt == 4'd11) begin
						tx_cnt <= '0;
						gap    <= 2'd3;
					end else begin
						tx_cnt <= tx_cnt + 4'd1;
					end
				end
			end

			// clock pulses only while a frame is active
			if (ps2_fall) begin
				lines_out.clk <= !((tx_cnt != 4'd0) || (rx_state == rx_bits) ||
					(rx_state == rx_stop) || (rx_state == rx_ack));
			end
		end
	end

	// shift registers
	always_ff @(posedge clk_sys) begin
		if (tx_start) begin
			tx_shift  <= fifo[rptr];
			tx_parity <= ~^fifo[rptr];
		end else if (ps2_rise && (tx_cnt >= 4'd1) && (tx_cnt <= 4'd8)) begin
			tx_shift <= tx_shift >> 1;
		end
		if (ps2_rise && (rx_state == rx_bits) && (rx_cnt < 4'd8))
			rx_shift <= {d1, rx_shift[7:1]};
		if (ps2_rise && (rx_state == rx_ack)) rd_data <= rx_shift;
	end

endmodule

//--- hw/ps2_reply_mux.sv
// ps2 readback selector
`timescale 1ns/1ns

module ps2_reply_mux (
	input  logic                                             clk_sys,
	input  logic                                             rst,
	input  ps2_pkg::ps2_rd_s [hps_bus_pkg::NUM_PS2_PORTS-1:0] rd,
	input  logic                                             sel_valid,
	input  logic [$clog2(hps_bus_pkg::NUM_PS2_PORTS)-1:0]    sel_port,
	output ps2_pkg::ps2_rd_s                                 reply,
	output logic [hps_bus_pkg::NUM_PS2_PORTS-1:0]            rd_ack
);

	ps2_pkg::ps2_rd_s                      selected;
	logic [hps_bus_pkg::NUM_PS2_PORTS-1:0] ack_next;

	assign selected = rd[sel_port];

	// acknowledge only a byte that is really there
	always_comb begin
		ack_next = '0;
		for (int i = 0; i < hps_bus_pkg::NUM_PS2_PORTS; i++) begin
			if (sel_valid && (sel_port == i) && rd[i].has_data) ack_next[i] = 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			reply  <= '0;
			rd_ack <= '0;
		end else begin
			rd_ack <= ack_next;
			if (sel_valid) reply <= selected;
		end
	end

endmodule

//--- hw/hps_io_top.sv
// host io bridge top
`timescale 1ns/1ns

module hps_io_top #(
	parameter int FIFO_DEPTH = 8,
	parameter int PS2_DIV    = 4
) (
	input  logic                                    clk_sys,
	input  logic                                    rst,
	input  logic                                    enable,
	input  logic                                    strobe,
	input  logic [15:0]                             din,
	input  logic [hps_bus_pkg::NUM_JOY-1:0][15:0]   rumble,
	input  ps2_pkg::ps2_lines_s                     kbd_in,
	input  ps2_pkg::ps2_lines_s                     mouse_in,
	output logic [15:0]                             dout,
	output logic [1:0]                              buttons,
	output logic [hps_bus_pkg::NUM_JOY-1:0][31:0]   joystick,
	output logic [hps_bus_pkg::STATUS_WORDS*16-1:0] status,
	output ps2_pkg::key_event_s                     ps2_key,
	output ps2_pkg::ps2_lines_s                     kbd_out,
	output ps2_pkg::ps2_lines_s                     mouse_out
);

	localparam int np = hps_bus_pkg::NUM_PS2_PORTS;

	ps2_pkg::ps2_wr_s    [np-1:0]    wr;
	ps2_pkg::ps2_rd_s    [np-1:0]    rd;
	ps2_pkg::ps2_lines_s [np-1:0]    lines_in;
	ps2_pkg::ps2_lines_s [np-1:0]    lines_out;
	logic                [np-1:0]    credit_return;
	logic                [np-1:0]    rd_ack;
	ps2_pkg::ps2_rd_s                reply;
	logic                            sel_valid;
	logic [$clog2(np)-1:0]           sel_port;

	// port 0 is the keyboard, port 1 the mouse
	assign lines_in[0] = kbd_in;
	assign lines_in[1] = mouse_in;
	assign kbd_out     = lines_out[0];
	assign mouse_out   = lines_out[1];

	hps_cmd_decoder #(
		.FIFO_DEPTH(FIFO_DEPTH),
		.PS2_DIV   (PS2_DIV)
	) u_decoder (
		.clk_sys      (clk_sys),
		.rst          (rst),
		.enable       (enable),
		.strobe       (strobe),
		.din          (din),
		.rumble       (rumble),
		.credit_return(credit_return),
		.reply        (reply),
		.dout         (dout),
		.buttons      (buttons),
		.joystick     (joystick),
		.status       (status),
		.ps2_key      (ps2_key),
		.wr           (wr),
		.sel_valid    (sel_valid),
		.sel_port     (sel_port)
	);

	for (genvar i = 0; i < np; i++) begin : g_port
		ps2_port #(
			.FIFO_DEPTH(FIFO_DEPTH),
			.PS2_DIV   (PS2_DIV)
		) u_port (
			.clk_sys      (clk_sys),
			.rst          (rst),
			.wr           (wr[i]),
			.lines_in     (lines_in[i]),
			.rd_ack       (rd_ack[i]),
			.lines_out    (lines_out[i]),
			.credit_return(credit_return[i]),
			.rd           (rd[i])
		);
	end

	ps2_reply_mux u_reply_mux (
		.clk_sys  (clk_sys),
		.rst      (rst),
		.rd       (rd),
		.sel_valid(sel_valid),
		.sel_port (sel_port),
		.reply    (reply),
		.rd_ack   (rd_ack)
	);

endmodule

//--- tb/hps_io_properties.sv
// decoder credit and bus checks
`timescale 1ns/1ns

module hps_io_properties #(
	parameter int FIFO_DEPTH = 8
) (
	input logic                                                             clk_sys,
	input logic                                                             rst,
	input logic                                                             enable,
	input logic                                                             strobe,
	input logic [hps_bus_pkg::NUM_PS2_PORTS-1:0][$clog2(FIFO_DEPTH+1)-1:0] credit,
	input logic [hps_bus_pkg::NUM_PS2_PORTS-1:0]                            credit_return,
	input ps2_pkg::ps2_wr_s [hps_bus_pkg::NUM_PS2_PORTS-1:0]               wr
);

	localparam int cw = $clog2(FIFO_DEPTH + 1);

	// bytes written into each port and not yet popped
	logic [hps_bus_pkg::NUM_PS2_PORTS-1:0][cw-1:0] in_flight;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			in_flight <= '0;
		end else begin
			for (int i = 0; i < hps_bus_pkg::NUM_PS2_PORTS; i++) begin
				in_flight[i] <= in_flight[i] + cw'(wr[i].valid) - cw'(credit_return[i]);
			end
		end
	end

	for (genvar i = 0; i < hps_bus_pkg::NUM_PS2_PORTS; i++) begin : g_credit
		// one credit per free fifo slot
		credit_bound: assert property (@(posedge clk_sys) disable iff (rst)
			credit[i] <= FIFO_DEPTH)
			else $error("credit counter of port %0d above fifo depth", i);

		write_needs_credit: assert property (@(posedge clk_sys) disable iff (rst)
			wr[i].valid |-> (in_flight[i] < cw'(FIFO_DEPTH)))
			else $error("write to port %0d without credit", i);
	end

	// words only inside a command frame
	strobe_in_frame: assert property (@(posedge clk_sys) disable iff (rst)
		strobe |-> enable)
		else $error("strobe seen while enable is low");

endmodule

bind hps_cmd_decoder hps_io_properties #(
	.FIFO_DEPTH(FIFO_DEPTH)
) u_properties (
	.clk_sys      (clk_sys),
	.rst          (rst),
	.enable       (enable),
	.strobe       (strobe),
	.credit       (credit),
	.credit_return(credit_return),
	.wr           (wr)
);

//--- tb/hps_io_tb.sv
// host io bridge testbench
`timescale 1ns/1ns

module hps_io_tb;

	localparam int FIFO_DEPTH      = 8;
	localparam int PS2_DIV         = 4;
	localparam int WATCHDOG_CYCLES = 200000;
	// one frame plus the gap behind it
	localparam int FRAME_CYCLES    = 16 * 2 * PS2_DIV;

	logic                                    clk_sys;
	logic                                    rst;
	logic                                    enable;
	logic                                    strobe;
	logic [15:0]                             din;
	logic [hps_bus_pkg::NUM_JOY-1:0][15:0]   rumble;
	ps2_pkg::ps2_lines_s                     kbd_in;
	ps2_pkg::ps2_lines_s                     mouse_in;
	logic [15:0]                             dout;
	logic [1:0]                              buttons;
	logic [hps_bus_pkg::NUM_JOY-1:0][31:0]   joystick;
	logic [hps_bus_pkg::STATUS_WORDS*16-1:0] status;
	ps2_pkg::key_event_s                     ps2_key;
	ps2_pkg::ps2_lines_s                     kbd_out;
	ps2_pkg::ps2_lines_s                     mouse_out;

	logic [31:0] lfsr_state = 32'h1bf1081e;
	bit          host_rx;
	bit          exp_toggle;
	ps2_pkg::key_event_s exp_key;
	logic [7:0]  kbd_frames[$];
	logic [7:0]  mouse_frames[$];
	logic [7:0]  sent[$];

	hps_io_top #(
		.FIFO_DEPTH(FIFO_DEPTH),
		.PS2_DIV   (PS2_DIV)
	) uut (
		.clk_sys  (clk_sys),
		.rst      (rst),
		.enable   (enable),
		.strobe   (strobe),
		.din      (din),
		.rumble   (rumble),
		.kbd_in   (kbd_in),
		.mouse_in (mouse_in),
		.dout     (dout),
		.buttons  (buttons),
		.joystick (joystick),
		.status   (status),
		.ps2_key  (ps2_key),
		.kbd_out  (kbd_out),
		.mouse_out(mouse_out)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	// taps 32 22 2 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic logic [15:0] lfsr_word();
		logic [15:0] w;
		w = '0;
		for (int i = 0; i < 16; i++) begin
			w = {w[14:0], lfsr_bit()};
		end
		return w;
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		if (expected !== actual)
			fail_run($sformatf("error %s expected %h actual %h", name, expected, actual));
	endtask

	task automatic cycles(input int n);
		repeat (n) @(posedge clk_sys);
	endtask

	task automatic send_word(input logic [15:0] w);
		@(posedge clk_sys);
		din    <= w;
		strobe <= 1'b1;
		@(posedge clk_sys);
		strobe <= 1'b0;
	endtask

	task automatic start_cmd(input logic [15:0] op);
		@(posedge clk_sys);
		enable <= 1'b1;
		send_word(op);
	endtask

	task automatic end_cmd();
		@(posedge clk_sys);
		enable <= 1'b0;
		cycles(2);
	endtask

	// one command carrying every queued byte
	task automatic send_ps2(input logic [15:0] op);
		hps_bus_pkg::ps2_byte_u b;
		start_cmd(op);
		foreach (sent[i]) begin
			b.fields.marker = 8'h00;
			b.fields.data   = sent[i];
			send_word(b.word);
		end
	endtask

	task automatic wait_frames(input bit mouse, input int n);
		int waited;
		waited = 0;
		while ((mouse ? mouse_frames.size() : kbd_frames.size()) < n) begin
			if (waited > n * FRAME_CYCLES * 2 + 200)
				fail_run("timed out waiting for ps2 frames");
			@(posedge clk_sys);
			waited++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// ps2 line models
	//////////////////////////////////////////////////////////////////////

	// first bit already sampled by the caller's edge
	task automatic capture_frame(input bit mouse);
		logic [10:0] bits;
		bits[0] = mouse ? mouse_out.dat : kbd_out.dat;
		for (int i = 1; i < 11; i++) begin
			if (mouse) @(negedge mouse_out.clk);
			else @(negedge kbd_out.clk);
			bits[i] = mouse ? mouse_out.dat : kbd_out.dat;
		end
		if (bits[0] !== 1'b0) fail_run("ps2 frame start bit is not low");
		if ((^bits[9:1]) !== 1'b1) fail_run("ps2 frame parity is not odd");
		if (bits[10] !== 1'b1) fail_run("ps2 frame stop bit is not high");
		if (mouse) mouse_frames.push_back(bits[8:1]);
		else kbd_frames.push_back(bits[8:1]);
	endtask

	initial forever begin
		@(negedge kbd_out.clk);
		// clock pulses of a host transfer are not device frames
		if (!host_rx) capture_frame(1'b0);
	end

	initial forever begin
		@(negedge mouse_out.clk);
		capture_frame(1'b1);
	end

	// host to device byte, bits change after each falling clock
	task automatic host_send_kbd(input logic [7:0] b);
		logic [9:0] seq;
		seq = {1'b1, ~^b, b};
		host_rx = 1'b1;
		@(posedge clk_sys);
		kbd_in.dat <= 1'b0;
		for (int i = 0; i < 10; i++) begin
			@(negedge kbd_out.clk);
			@(posedge clk_sys);
			kbd_in.dat <= seq[i];
		end
		@(negedge kbd_out.clk);
		check("ps2 receive ack", 1'b0, kbd_out.dat);
		@(posedge kbd_out.clk);
		host_rx = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic test_registers();
		logic [15:0]  lo;
		logic [15:0]  hi;
		logic [127:0] st;
		lo = lfsr_word();
		start_cmd(16'h0001);
		send_word(lo);
		end_cmd();
		check("cfg buttons", lo[1:0], buttons);
		for (int j = 0; j < 2; j++) begin
			lo = lfsr_word();
			hi = lfsr_word();
			start_cmd(j ? 16'h0003 : 16'h0002);
			send_word(lo);
			send_word(hi);
			end_cmd();
			check($sformatf("joystick %0d", j), {hi, lo}, joystick[j]);
		end
		start_cmd(16'h001e);
		for (int k = 0; k < 8; k++) begin
			lo = lfsr_word();
			st[16*k +: 16] = lo;
			send_word(lo);
		end
		end_cmd();
		check("status", st, status);
	endtask

	task automatic key_cmd(input string name, input bit skip, input bit pressed,
		input bit extended, input logic [7:0] code);
		send_ps2(16'h0005);
		if (skip) begin
			send_word(16'hff00);
			send_word(16'h002a);
		end
		end_cmd();
		// a skipped command leaves the last event in place
		if (!skip) begin
			exp_toggle = !exp_toggle;
			exp_key    = {exp_toggle, pressed, extended, code};
		end
		check(name, exp_key, ps2_key);
		wait_frames(1'b0, sent.size());
		foreach (sent[i]) check({name, " frame"}, sent[i], kbd_frames[i]);
		kbd_frames.delete();
		sent.delete();
	endtask

	task automatic test_key_events();
		exp_toggle = 1'b0;
		exp_key    = '0;
		sent = '{8'h1c};
		key_cmd("key make", 1'b0, 1'b1, 1'b0, 8'h1c);
		sent = '{8'hf0, 8'h1c};
		key_cmd("key break", 1'b0, 1'b0, 1'b0, 8'h1c);
		sent = '{8'he0, 8'h75};
		key_cmd("key extended", 1'b0, 1'b1, 1'b1, 8'h75);
		sent = '{8'he0, 8'h12, 8'he0, 8'h7c};
		key_cmd("print screen make", 1'b0, 1'b1, 1'b1, 8'h7c);
		sent = '{8'he0, 8'hf0, 8'h7c, 8'he0, 8'hf0, 8'h12};
		key_cmd("print screen break", 1'b0, 1'b0, 1'b1, 8'h7c);
		sent = '{8'he1, 8'h14, 8'h77, 8'he1, 8'hf0, 8'h14, 8'hf0, 8'h77};
		key_cmd("pause", 1'b0, 1'b1, 1'b1, 8'h77);
		sent = '{8'h1c};
		key_cmd("key skip", 1'b1, 1'b0, 1'b0, 8'h00);
	endtask

	task automatic test_kbd_transmit();
		logic [15:0] w;
		kbd_frames.delete();
		mouse_frames.delete();
		for (int i = 0; i < 4; i++) begin
			w = lfsr_word();
			sent.push_back(w[7:0]);
		end
		send_ps2(16'h0005);
		end_cmd();
		wait_frames(1'b0, 4);
		foreach (sent[i]) check("kbd transmit", sent[i], kbd_frames[i]);
		check("mouse frames while kbd sends", 0, mouse_frames.size());
		check("mouse lines idle", 2'b11, mouse_out);
		kbd_frames.delete();
		sent.delete();
	endtask

	task automatic test_back_pressure();
		logic [15:0] w;
		@(posedge clk_sys);
		mouse_in <= '{clk: 1'b0, dat: 1'b0};
		for (int i = 0; i < 12; i++) begin
			w = lfsr_word();
			sent.push_back(w[7:0]);
		end
		send_ps2(16'h0004);
		end_cmd();
		cycles(4 * FRAME_CYCLES);
		check("mouse frames while held", 0, mouse_frames.size());
		@(posedge clk_sys);
		mouse_in <= '{clk: 1'b1, dat: 1'b1};
		wait_frames(1'b1, FIFO_DEPTH);
		// time for any extra frame to show up
		cycles(6 * FRAME_CYCLES);
		check("mouse frame count", FIFO_DEPTH, mouse_frames.size());
		for (int i = 0; i < FIFO_DEPTH; i++) check("mouse frame", sent[i], mouse_frames[i]);
		mouse_frames.delete();
		sent.delete();
	endtask

	task automatic test_receive();
		host_send_kbd(8'hed);
		start_cmd(16'h0021);
		send_word(16'h0000);
		cycles(3);
		check("ps2 read", 16'h01ed, dout);
		end_cmd();
		start_cmd(16'h0021);
		send_word(16'h0000);
		cycles(3);
		check("ps2 read again", 1'b0, dout[8]);
		end_cmd();
	endtask

	task automatic test_rumble();
		start_cmd(16'h013f);
		cycles(3);
		check("rumble", rumble[1], dout);
		end_cmd();
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("watchdog expired before the tests finished");
		$display("CHECKS FAILED");
		$fatal(1, "timeout");
	end

	initial begin
		rst      = 1'b1;
		enable   = 1'b0;
		strobe   = 1'b0;
		din      = '0;
		rumble   = '0;
		kbd_in   = '{clk: 1'b1, dat: 1'b1};
		mouse_in = '{clk: 1'b1, dat: 1'b1};
		host_rx  = 1'b0;
		repeat (5) @(posedge clk_sys);
		rst       <= 1'b0;
		rumble[0] <= lfsr_word();
		rumble[1] <= lfsr_word();
		cycles(2);
		test_registers();
		test_key_events();
		test_kbd_transmit();
		test_back_pressure();
		test_receive();
		test_rumble();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

//--- sim.f
hw/hps_bus_pkg.sv
hw/ps2_pkg.sv
hw/hps_cmd_decoder.sv
hw/ps2_port.sv
hw/ps2_reply_mux.sv
hw/hps_io_top.sv
tb/hps_io_properties.sv
tb/hps_io_tb.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -j 0 \
	-f sim.f \
	--top-module hps_io_tb \
	-o hps_io_sim
./obj_dir/hps_io_sim
